/* csr_consts.svh */
/*
 CSR index map, mcause codes, interrupt bit positions,
 identity defaults and the default wall-time prescale.
*/
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine trap setup and handling.
`define CSR_MSTATUS 12'h300
`define CSR_MIE 12'h304
`define CSR_MTVEC 12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MIP 12'h344

// Unprivileged counters, low and high halves.
`define CSR_CYCLE 12'hC00
`define CSR_TIME 12'hC01
`define CSR_INSTRET 12'hC02
`define CSR_CYCLEH 12'hC80
`define CSR_TIMEH 12'hC81
`define CSR_INSTRETH 12'hC82

// Machine identity.
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID 12'hF12
`define CSR_MIMPID 12'hF13
`define CSR_MHARTID 12'hF14

// Bit positions in mstatus, mie and mip.
`define CSR_BIT_MIE 3
`define CSR_BIT_MPIE 7
`define CSR_BIT_EXTERNAL 11
`define CSR_BIT_TIMER 7
`define CSR_BIT_SOFTWARE 3

// Cause codes, top bit marks an asynchronous interrupt.
`define CSR_CAUSE_EXTERNAL 32'h8000_000B
`define CSR_CAUSE_TIMER 32'h8000_0007
`define CSR_CAUSE_ECALL 32'h0000_000B

`define CSR_DEFAULT_VENDORID 32'h0000_0000
`define CSR_DEFAULT_ARCHID 32'h0000_0000
`define CSR_DEFAULT_IMPID 32'h0000_0001
`define CSR_DEFAULT_HARTID 32'h0000_0000
// Clocks per wall-time tick.
`define CSR_DEFAULT_TIME_PRESCALE 1000

`endif

/* csr_pkg.sv */
/*
 Shared CSR types: index, data word, 64-bit counter
 and the taken-interrupt source.
*/
package csr_pkg;

	// 12-bit CSR address.
	typedef logic [11:0] csr_index_t;

	// CSR data word, also used for program counters.
	typedef logic [31:0] csr_word_t;

	// Free-running counter, read as two words.
	typedef logic [63:0] csr_count_t;

	// Interrupt currently in service.
	// IRQ_NONE doubles as the idle state of the issue FSM.
	typedef enum logic [1:0] {
		IRQ_NONE,
		IRQ_EXTERNAL,
		IRQ_TIMER,
		IRQ_SOFTWARE
	} irq_source_t;

endpackage

/* csr_access_if.sv */
/*
 CSR access path: index, write strobe, write data and read data.
*/
`timescale 1ns/1ps

interface csr_access_if;

	csr_pkg::csr_index_t index;
	logic write;
	csr_pkg::csr_word_t wdata;
	csr_pkg::csr_word_t rdata;

	// Issuer of accesses.
	modport master (output index, output write, output wdata, input rdata);

	// Register file, owns the read data.
	modport regfile (input index, input write, input wdata, output rdata);

	// Observer that only decodes the index.
	modport reader (input index);

endinterface

/* csr_counters.sv */
/*
 Cycle, prescaled wall-time and retired-instruction counters
 with the read mux for their low and high halves.
*/
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_counters #(
	parameter int TIME_PRESCALE = `CSR_DEFAULT_TIME_PRESCALE
)(
	input logic i_clock,
	input logic i_reset,
	csr_access_if.reader bus,
	input logic i_retire,
	output csr_pkg::csr_word_t o_rdata
);
	localparam int DIV_WIDTH = $clog2(TIME_PRESCALE + 1);

	csr_pkg::csr_count_t cycle_count;
	csr_pkg::csr_count_t time_count;
	csr_pkg::csr_count_t instret_count;
	logic [DIV_WIDTH-1:0] divider;
	logic time_tick;

	assign time_tick = (divider == DIV_WIDTH'(TIME_PRESCALE - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycle_count <= '0;
			time_count <= '0;
			instret_count <= '0;
			divider <= '0;
		end else begin
			cycle_count <= cycle_count + 64'd1;
			if (time_tick) begin
				divider <= '0;
				time_count <= time_count + 64'd1;
			end else begin
				divider <= divider + 1'b1;
			end
			if (i_retire)
				instret_count <= instret_count + 64'd1;
		end
	end

	// Half select by index.
	always_comb begin
		case (bus.index)
			`CSR_CYCLE: o_rdata = cycle_count[31:0];
			`CSR_CYCLEH: o_rdata = cycle_count[63:32];
			`CSR_TIME: o_rdata = time_count[31:0];
			`CSR_TIMEH: o_rdata = time_count[63:32];
			`CSR_INSTRET: o_rdata = instret_count[31:0];
			`CSR_INSTRETH: o_rdata = instret_count[63:32];
			default: o_rdata = '0;
		endcase
	end

	a_divider_range: assert property (@(posedge i_clock) disable iff (i_reset)
		divider < DIV_WIDTH'(TIME_PRESCALE));

endmodule

/* csr_trap_file.sv */
/*
 Machine CSR registers, read mux and write decode, interrupt
 latching, fixed-priority issue, dispatch and mret handling.
*/
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_trap_file #(
	parameter csr_pkg::csr_word_t VENDORID = `CSR_DEFAULT_VENDORID,
	parameter csr_pkg::csr_word_t ARCHID = `CSR_DEFAULT_ARCHID,
	parameter csr_pkg::csr_word_t IMPID = `CSR_DEFAULT_IMPID,
	parameter csr_pkg::csr_word_t HARTID = `CSR_DEFAULT_HARTID
)(
	input logic i_clock,
	input logic i_reset,
	csr_access_if.regfile bus,
	input csr_pkg::csr_word_t i_counter_rdata,
	input logic i_timer_irq,
	input logic i_external_irq,
	input logic i_ecall,
	input logic i_mret,
	input logic i_irq_dispatched,
	input csr_pkg::csr_word_t i_irq_epc,
	output csr_pkg::csr_word_t o_epc,
	output csr_pkg::csr_word_t o_scratch,
	output logic o_irq_pending,
	output csr_pkg::csr_word_t o_irq_pc,
	output logic o_external_irq_enable
);
	logic mstatus_mie;
	logic mstatus_mpie;
	logic mie_meie;
	logic mie_mtie;
	logic mie_msie;
	logic mip_meip;
	logic mip_mtip;
	logic mip_msip;
	csr_pkg::csr_word_t mtvec;
	csr_pkg::csr_word_t mepc;
	csr_pkg::csr_word_t mcause;
	csr_pkg::csr_word_t mscratch;
	csr_pkg::irq_source_t taken_source;

	csr_pkg::csr_word_t mstatus_word;
	csr_pkg::csr_word_t mie_word;
	csr_pkg::csr_word_t mip_word;
	logic external_ready;
	logic timer_ready;
	logic software_ready;
	logic issue;

	assign mstatus_word = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
	assign mie_word = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
	assign mip_word = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};

	// Pending and enabled sources.
	assign external_ready = mip_meip && mie_meie;
	assign timer_ready = mip_mtip && mie_mtie;
	assign software_ready = mip_msip && mie_msie;
	assign issue = mstatus_mie && !o_irq_pending &&
		(external_ready || timer_ready || software_ready);

	assign o_epc = mepc;
	assign o_scratch = mscratch;
	assign o_external_irq_enable = mie_meie;

	// Counter indices fall through to the counter block word.
	always_comb begin
		case (bus.index)
			`CSR_MSTATUS: bus.rdata = mstatus_word;
			`CSR_MIE: bus.rdata = mie_word;
			`CSR_MIP: bus.rdata = mip_word;
			`CSR_MTVEC: bus.rdata = mtvec;
			`CSR_MEPC: bus.rdata = mepc;
			`CSR_MCAUSE: bus.rdata = mcause;
			`CSR_MSCRATCH: bus.rdata = mscratch;
			`CSR_MVENDORID: bus.rdata = VENDORID;
			`CSR_MARCHID: bus.rdata = ARCHID;
			`CSR_MIMPID: bus.rdata = IMPID;
			`CSR_MHARTID: bus.rdata = HARTID;
			`CSR_CYCLE, `CSR_CYCLEH, `CSR_TIME, `CSR_TIMEH,
			`CSR_INSTRET, `CSR_INSTRETH: bus.rdata = i_counter_rdata;
			default: bus.rdata = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie <= 1'b1;
			mie_mtie <= 1'b1;
			mie_msie <= 1'b1;
			mip_meip <= 1'b0;
			mip_mtip <= 1'b0;
			mip_msip <= 1'b0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
			mscratch <= '0;
			taken_source <= csr_pkg::IRQ_NONE;
			o_irq_pending <= 1'b0;
		end else begin
			if (bus.write) begin
				case (bus.index)
					`CSR_MSTATUS: begin
						mstatus_mie <= bus.wdata[`CSR_BIT_MIE];
						mstatus_mpie <= bus.wdata[`CSR_BIT_MPIE];
					end
					`CSR_MIE: begin
						mie_meie <= bus.wdata[`CSR_BIT_EXTERNAL];
						mie_mtie <= bus.wdata[`CSR_BIT_TIMER];
						mie_msie <= bus.wdata[`CSR_BIT_SOFTWARE];
					end
					`CSR_MIP: begin
						mip_meip <= bus.wdata[`CSR_BIT_EXTERNAL];
						mip_mtip <= bus.wdata[`CSR_BIT_TIMER];
						mip_msip <= bus.wdata[`CSR_BIT_SOFTWARE];
					end
					`CSR_MTVEC: mtvec <= bus.wdata;
					`CSR_MEPC: mepc <= bus.wdata;
					`CSR_MSCRATCH: mscratch <= bus.wdata;
					default: ;
				endcase
			end

			// Requests latch only when enabled.
			if (i_external_irq && mie_meie)
				mip_meip <= 1'b1;
			if (i_timer_irq && mie_mtie)
				mip_mtip <= 1'b1;
			if (i_ecall && mie_msie)
				mip_msip <= 1'b1;

			// External beats timer beats software.
			if (issue) begin
				o_irq_pending <= 1'b1;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
				if (external_ready) begin
					mcause <= `CSR_CAUSE_EXTERNAL;
					taken_source <= csr_pkg::IRQ_EXTERNAL;
				end else if (timer_ready) begin
					mcause <= `CSR_CAUSE_TIMER;
					taken_source <= csr_pkg::IRQ_TIMER;
				end else begin
					mcause <= `CSR_CAUSE_ECALL;
					taken_source <= csr_pkg::IRQ_SOFTWARE;
				end
			end

			if (i_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b0;
				case (taken_source)
					csr_pkg::IRQ_EXTERNAL: mip_meip <= 1'b0;
					csr_pkg::IRQ_TIMER: mip_mtip <= 1'b0;
					csr_pkg::IRQ_SOFTWARE: mip_msip <= 1'b0;
					default: ;
				endcase
				taken_source <= csr_pkg::IRQ_NONE;
			end

			if (i_irq_dispatched) begin
				mepc <= i_irq_epc;
				o_irq_pending <= 1'b0;
			end
		end
	end

	// Handler address captured at issue.
	always_ff @(posedge i_clock) begin
		if (issue)
			o_irq_pc <= mtvec;
	end

	a_pending_has_source: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_irq_pending) |-> taken_source != csr_pkg::IRQ_NONE);

	a_dispatch_when_pending: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |-> o_irq_pending);

	// Nested traps are not supported.
	a_mret_not_nested: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mret |-> !mstatus_mie);

endmodule

/* csr_unit.sv */
/*
 Machine-mode CSR subsystem top level with plain ports.
 Binds the access path to the register file and the counters.
*/
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit #(
	parameter csr_pkg::csr_word_t VENDORID = `CSR_DEFAULT_VENDORID,
	parameter csr_pkg::csr_word_t ARCHID = `CSR_DEFAULT_ARCHID,
	parameter csr_pkg::csr_word_t IMPID = `CSR_DEFAULT_IMPID,
	parameter csr_pkg::csr_word_t HARTID = `CSR_DEFAULT_HARTID,
	parameter int TIME_PRESCALE = `CSR_DEFAULT_TIME_PRESCALE
)(
	input logic i_clock,
	input logic i_reset,
	input csr_pkg::csr_index_t i_csr_index,
	input logic i_csr_write,
	input csr_pkg::csr_word_t i_csr_wdata,
	input logic i_timer_irq,
	input logic i_external_irq,
	input logic i_ecall,
	input logic i_mret,
	input logic i_irq_dispatched,
	input csr_pkg::csr_word_t i_irq_epc,
	input logic i_retire,
	output csr_pkg::csr_word_t o_csr_rdata,
	output csr_pkg::csr_word_t o_epc,
	output csr_pkg::csr_word_t o_scratch,
	output logic o_irq_pending,
	output csr_pkg::csr_word_t o_irq_pc,
	output logic o_external_irq_enable
);
	csr_pkg::csr_word_t counter_rdata;

	csr_access_if csr_bus ();

	assign csr_bus.index = i_csr_index;
	assign csr_bus.write = i_csr_write;
	assign csr_bus.wdata = i_csr_wdata;
	assign o_csr_rdata = csr_bus.rdata;

	csr_trap_file #(
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) u_trap_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(csr_bus.regfile),
		.i_counter_rdata(counter_rdata),
		.i_timer_irq(i_timer_irq),
		.i_external_irq(i_external_irq),
		.i_ecall(i_ecall),
		.i_mret(i_mret),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_epc(o_epc),
		.o_scratch(o_scratch),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.o_external_irq_enable(o_external_irq_enable)
	);

	csr_counters #(
		.TIME_PRESCALE(TIME_PRESCALE)
	) u_counters (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(csr_bus.reader),
		.i_retire(i_retire),
		.o_rdata(counter_rdata)
	);

endmodule

/* csr_unit_tb.sv */
/*
 Testbench for the CSR unit. Reads the stimulus file, drives the
 ports on falling edges and checks reads, trap outputs and counters.
*/
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_tb;
	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int STIM_DEPTH = 64;
	localparam int MARGIN_CYCLES = 40;

	logic i_clock;
	logic i_reset;
	csr_pkg::csr_index_t i_csr_index;
	logic i_csr_write;
	csr_pkg::csr_word_t i_csr_wdata;
	logic i_timer_irq;
	logic i_external_irq;
	logic i_ecall;
	logic i_mret;
	logic i_irq_dispatched;
	csr_pkg::csr_word_t i_irq_epc;
	logic i_retire;
	csr_pkg::csr_word_t o_csr_rdata;
	csr_pkg::csr_word_t o_epc;
	csr_pkg::csr_word_t o_scratch;
	logic o_irq_pending;
	csr_pkg::csr_word_t o_irq_pc;
	logic o_external_irq_enable;

	// One record per line: op, index or strobe, data, expected.
	logic [79:0] stim_mem [0:STIM_DEPTH-1];
	int budget_cycles;
	logic budget_ready = 1'b0;
	int retire_count;

	csr_unit #(
		.VENDORID(32'h0000_0A5C),
		.ARCHID(32'h0000_0012),
		.IMPID(32'h0000_0003),
		.HARTID(32'h0000_0002),
		.TIME_PRESCALE(4)
	) i_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_csr_index(i_csr_index),
		.i_csr_write(i_csr_write),
		.i_csr_wdata(i_csr_wdata),
		.i_timer_irq(i_timer_irq),
		.i_external_irq(i_external_irq),
		.i_ecall(i_ecall),
		.i_mret(i_mret),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.i_retire(i_retire),
		.o_csr_rdata(o_csr_rdata),
		.o_epc(o_epc),
		.o_scratch(o_scratch),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.o_external_irq_enable(o_external_irq_enable)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
	end

	task automatic fail_run(input string reason);
		$display("Errors found");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input csr_pkg::csr_word_t actual,
		input csr_pkg::csr_word_t expected, input string what);
		if (actual !== expected) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
			fail_run("Stopped at the first mismatch");
		end
	endtask

	task automatic write_csr(input csr_pkg::csr_index_t index, input csr_pkg::csr_word_t data);
		i_csr_index = index;
		i_csr_write = 1'b1;
		i_csr_wdata = data;
		@(negedge i_clock);
		i_csr_write = 1'b0;
	endtask

	// Read data is combinational, sampled one falling edge later.
	task automatic read_csr(input csr_pkg::csr_index_t index, output csr_pkg::csr_word_t value);
		i_csr_index = index;
		@(negedge i_clock);
		value = o_csr_rdata;
	endtask

	task automatic pulse_strobe(input csr_pkg::csr_index_t sel, input csr_pkg::csr_word_t data);
		case (sel)
			12'h001: i_timer_irq = 1'b1;
			12'h002: i_external_irq = 1'b1;
			12'h003: i_ecall = 1'b1;
			12'h004: i_mret = 1'b1;
			12'h005: begin
				i_irq_dispatched = 1'b1;
				i_irq_epc = data;
			end
			12'h006: begin
				i_retire = 1'b1;
				retire_count++;
			end
			default: fail_run($sformatf("Unknown strobe %h in the stimulus file", sel));
		endcase
		@(negedge i_clock);
		i_timer_irq = 1'b0;
		i_external_irq = 1'b0;
		i_ecall = 1'b0;
		i_mret = 1'b0;
		i_irq_dispatched = 1'b0;
		i_retire = 1'b0;
	endtask

	// Clock cycles the stimulus needs, up to its end marker.
	function automatic int stim_cycles();
		int total;
		logic [3:0] op;
		total = 0;
		for (int i = 0; i < STIM_DEPTH; i++) begin
			op = stim_mem[i][79:76];
			if (op == 4'h0)
				break;
			if (op == 4'h4)
				total += int'(stim_mem[i][63:32]);
			else if (op == 4'h8)
				total += int'(stim_mem[i][63:32]) + 1;
			else
				total += 2;
		end
		return total;
	endfunction

	initial begin
		wait (budget_ready);
		#(budget_cycles * CLOCK_PERIOD);
		fail_run("Watchdog timeout, the stimulus did not finish in time");
	end

	initial begin : run_stimulus
		int pc;
		logic done;
		logic [3:0] op;
		csr_pkg::csr_index_t sel;
		csr_pkg::csr_word_t data;
		csr_pkg::csr_word_t expected;
		csr_pkg::csr_word_t first_read;
		csr_pkg::csr_word_t second_read;
		i_reset = 1'b1;
		i_csr_index = '0;
		i_csr_write = 1'b0;
		i_csr_wdata = '0;
		i_timer_irq = 1'b0;
		i_external_irq = 1'b0;
		i_ecall = 1'b0;
		i_mret = 1'b0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = '0;
		i_retire = 1'b0;
		retire_count = 0;
		$readmemh("csr_unit_stim.txt", stim_mem);
		budget_cycles = RESET_CYCLES + MARGIN_CYCLES + stim_cycles();
		budget_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge i_clock);
		i_reset = 1'b0;
		pc = 0;
		done = 1'b0;
		while (!done) begin
			{op, sel, data, expected} = stim_mem[pc];
			case (op)
				4'h0: done = 1'b1;
				4'h1: begin
					write_csr(sel, data);
					// Mirrored outputs follow the written CSR.
					if (sel == `CSR_MSCRATCH)
						check_value(o_scratch, data, "o_scratch");
					if (sel == `CSR_MIE)
						check_value({31'b0, o_external_irq_enable},
							{31'b0, data[`CSR_BIT_EXTERNAL]}, "o_external_irq_enable");
				end
				4'h2: begin
					read_csr(sel, first_read);
					check_value(first_read, expected, $sformatf("CSR %h", sel));
				end
				4'h3: pulse_strobe(sel, data);
				4'h4: repeat (int'(data)) @(negedge i_clock);
				4'h5: check_value({31'b0, o_irq_pending}, expected, "o_irq_pending");
				4'h6: check_value(o_irq_pc, expected, "o_irq_pc");
				4'h7: check_value(o_epc, expected, "o_epc");
				4'h8: begin
					// Cycle count must advance by exactly the wait.
					read_csr(`CSR_CYCLE, first_read);
					repeat (int'(data)) @(negedge i_clock);
					check_value(o_csr_rdata - first_read, data, "cycle delta");
				end
				4'h9: begin
					read_csr(`CSR_INSTRET, first_read);
					check_value(first_read, retire_count, "instret");
				end
				4'hA: begin
					read_csr(`CSR_CYCLE, first_read);
					read_csr(`CSR_TIME, second_read);
					expected = (first_read + 32'd1) / 32'd4;
					check_value({31'b0, (second_read + 32'd1 >= expected) &&
						(second_read <= expected + 32'd1)}, 32'd1, "time against cycle / 4");
				end
				default: fail_run($sformatf("Unknown operation %h at stimulus entry %0d", op, pc));
			endcase
			pc++;
			if (!done && pc == STIM_DEPTH)
				fail_run("The stimulus file has no end marker");
		end
		$display("No errors");
		$finish;
	end

endmodule

/* csr_unit_stim.txt */
// op_index_data_expected in hex; op 1 write 2 read 3 strobe 4 wait 5 pending 6 irq_pc 7 epc
// 8 cycle delta 9 instret A time 0 end; strobes 1 timer 2 ext 3 ecall 4 mret 5 dispatch 6 retire
2_304_00000000_00000888
2_300_00000000_00000000
1_305_00001000_00000000
2_305_00000000_00001000
1_340_CAFE1234_00000000
2_340_00000000_CAFE1234
1_341_00000ABC_00000000
2_341_00000000_00000ABC
7_000_00000000_00000ABC
1_300_FFFFFFFF_00000000
2_300_00000000_00000088
1_300_00000000_00000000
1_7FF_12345678_00000000
2_7FF_00000000_00000000
2_F11_00000000_00000A5C
2_F12_00000000_00000012
2_F13_00000000_00000003
2_F14_00000000_00000002
1_304_00000080_00000000
3_002_00000000_00000000
3_001_00000000_00000000
2_344_00000000_00000080
1_304_00000888_00000000
3_002_00000000_00000000
3_003_00000000_00000000
2_344_00000000_00000888
4_000_00000003_00000000
5_000_00000000_00000000
1_300_00000008_00000000
4_000_00000001_00000000
5_000_00000000_00000001
6_000_00000000_00001000
2_342_00000000_8000000B
2_300_00000000_00000080
3_005_00002000_00000000
5_000_00000000_00000000
7_000_00000000_00002000
3_004_00000000_00000000
2_344_00000000_00000088
5_000_00000000_00000001
2_342_00000000_80000007
3_005_00002004_00000000
3_004_00000000_00000000
2_344_00000000_00000008
2_342_00000000_0000000B
3_005_00002008_00000000
7_000_00000000_00002008
3_004_00000000_00000000
2_344_00000000_00000000
2_300_00000000_00000008
8_000_00000005_00000000
3_006_00000000_00000000
3_006_00000000_00000000
3_006_00000000_00000000
9_000_00000000_00000000
2_C82_00000000_00000000
A_000_00000000_00000000
0_000_00000000_00000000

/* sources.f */
+incdir+.
csr_pkg.sv
csr_access_if.sv
csr_counters.sv
csr_trap_file.sv
csr_unit.sv
csr_unit_tb.sv

/* run.sh */
#!/bin/sh
# Compile the CSR unit with its testbench and run it under Verilator.
# The run passes only if the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module csr_unit_tb \
	-o csr_unit_sim || exit 1
sim_out=$(./obj_dir/csr_unit_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "No errors" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
